// ==== verif/shuffle_vectors.txt ====
// Row: test_id ew len last hold input_data, with expected_data on the following line
// ew 0/1/2 is 8/16/32 bit, len is beats minus one, hold withholds credits for the test
1 0 1 0 0 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffddddbbbb9999eeeeccccaaaa888877775555333311116666444422220000
1 0 1 1 0 0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
000022224444666611113333555577778888aaaacccceeee9999bbbbddddffff
2 1 1 0 0 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffeeeebbbbaaaaddddcccc9999888877776666333322225555444411110000
2 1 1 1 0 0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
0000111144445555222233336666777788889999ccccddddaaaabbbbeeeeffff
3 2 0 1 0 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
4 0 0 1 0 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffddddbbbb9999eeeeccccaaaa888877775555333311116666444422220000
4 1 0 1 0 0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
0000111144445555222233336666777788889999ccccddddaaaabbbbeeeeffff
4 2 0 1 0 0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
5 0 4 0 1 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffddddbbbb9999eeeeccccaaaa888877775555333311116666444422220000
5 0 4 0 1 0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
000022224444666611113333555577778888aaaacccceeee9999bbbbddddffff
5 0 4 0 1 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffddddbbbb9999eeeeccccaaaa888877775555333311116666444422220000
5 0 4 0 1 0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
000022224444666611113333555577778888aaaacccceeee9999bbbbddddffff
5 0 4 1 1 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffddddbbbb9999eeeeccccaaaa888877775555333311116666444422220000
6 2 0 1 0 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
6 1 0 1 0 ffffeeeeddddccccbbbbaaaa9999888877776666555544443333222211110000
ffffeeeebbbbaaaaddddcccc9999888877776666333322225555444411110000
6 0 0 1 0 0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
000022224444666611113333555577778888aaaacccceeee9999bbbbddddffff
6 1 0 1 0 0000111122223333444455556666777788889999aaaabbbbccccddddeeeeffff
0000111144445555222233336666777788889999ccccddddaaaabbbbeeeeffff

// ==== sim.f ====
hw/shuffle_cfg_pkg.sv
hw/shuffle_req_pkg.sv
hw/req_tracker.sv
hw/shuffle_stage.sv
hw/credit_counter.sv
hw/shuffle_unit.sv
verif/tb_clock_gen.sv
verif/tb_shuffle_unit.sv

// ==== Bender.yml ====
package:
  name: shuffle_unit

sources:
  # Packages first, then leaf modules, then the top level
  - files:
      - hw/shuffle_cfg_pkg.sv
      - hw/shuffle_req_pkg.sv
      - hw/req_tracker.sv
      - hw/shuffle_stage.sv
      - hw/credit_counter.sv
      - hw/shuffle_unit.sv

  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_shuffle_unit.sv

// ==== verif/tb_shuffle_unit.sv ====
////////////////////
// Testbench for the read shuffle unit, driven from verif/shuffle_vectors.txt.
// Each test starts with an empty tracker and the full credit pool.
// Inputs change 2 ns after the rising edge and outputs are sampled on the falling edge.
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_shuffle_unit;

  localparam int unsigned NumTrackers = 4;
  localparam int unsigned CreditDepth = 4;
  localparam int unsigned NumRows     = 17;
  localparam int unsigned RowWords    = 7;
  localparam int unsigned Timeout     = 1000;
  localparam int unsigned HoldCycles  = 30;

  logic                     clk;
  logic                     rst_n;
  logic                     req_valid;
  shuffle_req_pkg::rd_req_t req;
  logic                     req_ready;
  logic                     in_valid;
  shuffle_req_pkg::beat_t   in_beat;
  logic                     in_ready;
  logic                     out_valid;
  shuffle_req_pkg::beat_t   out_beat;
  logic                     credit;

  // Seven words per row as test id, ew, len, last, hold, input data and expected data
  logic [shuffle_cfg_pkg::TOTAL_DATA_WIDTH-1:0] vec_mem [NumRows*RowWords];

  int  seed = 5;
  int  cycle_cnt = 0;
  int  errors = 0;
  int  checks = 0;
  int  tests_run = 0;
  int  owed = 0;
  int  out_count = 0;
  int  first_in_cycle = 0;
  bit  hold = 1'b0;

  tb_clock_gen #(
    .HalfPeriod  (10),
    .ResetCycles (10)
  ) i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  shuffle_unit #(
    .NumTrackers (NumTrackers),
    .CreditDepth (CreditDepth)
  ) uut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .in_valid_i  (in_valid),
    .in_beat_i   (in_beat),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_beat_o  (out_beat),
    .credit_i    (credit)
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Consumer frees received beats at random moments unless told to hold
  always @(posedge clk) begin
    #2;
    if (rst_n && !hold && owed > 0 && ($random(seed) & 1) == 1) begin
      credit = 1'b1;
      owed--;
    end else begin
      credit = 1'b0;
    end
  end

  function automatic logic [shuffle_cfg_pkg::TOTAL_DATA_WIDTH-1:0] vec_field(int row, int col);
    return vec_mem[row*RowWords+col];
  endfunction

  function automatic string test_name(int id);
    case (id)
      1: return "ew8_swap";
      2: return "ew16_swap";
      3: return "ew32_pass";
      4: return "mixed_widths";
      5: return "credit_hold";
      6: return "tracker_full";
      default: return $sformatf("test_%0d", id);
    endcase
  endfunction

  task automatic abort_run(string what);
    $display("Timeout: %s", what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic send_request(int row);
    int waited;
    waited = 0;
    req_valid = 1'b1;
    req.ew    = shuffle_cfg_pkg::ew_t'(vec_field(row, 1));
    req.len   = shuffle_cfg_pkg::beat_len_t'(vec_field(row, 2));
    @(negedge clk);
    while (!req_ready && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready) abort_run("request was never accepted");
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic send_beats(int first, int last);
    int waited;
    for (int r = first; r <= last; r++) begin
      waited = 0;
      in_valid      = 1'b1;
      in_beat.data  = vec_field(r, 5);
      in_beat.last  = (vec_field(r, 3) != '0);
      @(negedge clk);
      while (!in_ready && waited < Timeout) begin
        @(negedge clk);
        waited++;
      end
      if (!in_ready) abort_run("input beat was never accepted");
      if (r == first) first_in_cycle = cycle_cnt;
      @(posedge clk);
      #2;
    end
    in_valid = 1'b0;
  endtask

  task automatic collect_beats(int first, int last, string name);
    int                     waited;
    shuffle_req_pkg::beat_t exp;
    for (int r = first; r <= last; r++) begin
      waited = 0;
      @(negedge clk);
      while (!out_valid && waited < Timeout) begin
        @(negedge clk);
        waited++;
      end
      if (!out_valid) abort_run("expected output beat never appeared");
      exp.data = vec_field(r, 6);
      exp.last = (vec_field(r, 3) != '0);
      checks++;
      assert (out_beat === exp) else begin
        $display("** Error %s beat %0d: expected %h, got %h", name, r - first, exp, out_beat);
        errors++;
      end
      // Pipeline is empty and credits are full when a test begins
      if (r == first) begin
        checks++;
        assert (cycle_cnt - first_in_cycle == shuffle_cfg_pkg::NUM_STAGES) else begin
          $display("** Error %s latency: expected %0d, got %0d", name,
                   shuffle_cfg_pkg::NUM_STAGES, cycle_cnt - first_in_cycle);
          errors++;
        end
      end
      out_count++;
      owed++;
    end
  endtask

  task automatic release_credits_later(string name);
    repeat (HoldCycles) @(negedge clk);
    checks++;
    assert (out_count <= CreditDepth) else begin
      $display("** Error %s beats without credit: expected at most %0d, got %0d", name,
               CreditDepth, out_count);
      errors++;
    end
    hold = 1'b0;
  endtask

  task automatic wait_credits_home();
    int waited;
    waited = 0;
    while (owed > 0 && waited < Timeout) begin
      @(posedge clk);
      waited++;
    end
    if (owed > 0) abort_run("returned credits never drained");
    @(posedge clk);
    #2;
  endtask

  task automatic run_test(int first, int last);
    int    errors_before;
    int    nreq;
    string name;
    errors_before = errors;
    nreq          = 0;
    out_count     = 0;
    name          = test_name(int'(vec_field(first, 0)));
    hold          = (vec_field(first, 4) != '0);
    // A request opens at the first row and after every row flagged last
    for (int r = first; r <= last; r++) begin
      if (r == first || vec_field(r - 1, 3) != '0) begin
        send_request(r);
        nreq++;
      end
    end
    if (nreq == NumTrackers) begin
      checks++;
      assert (!req_ready) else begin
        $display("** Error %s req_ready with %0d requests held: expected 0, got %0b",
                 name, nreq, req_ready);
        errors++;
      end
    end
    fork
      send_beats(first, last);
      collect_beats(first, last, name);
      begin
        if (hold) release_credits_later(name);
      end
    join
    wait_credits_home();
    checks++;
    assert (req_ready) else begin
      $display("** Error %s req_ready after last beat left: expected 1, got %0b",
               name, req_ready);
      errors++;
    end
    tests_run++;
    $display("%-14s %0d beats, %0d requests: %s", name, last - first + 1, nreq,
             (errors == errors_before) ? "pass" : "fail");
  endtask

  initial begin
    int first;
    int waited;
    req_valid = 1'b0;
    req       = '0;
    in_valid  = 1'b0;
    in_beat   = '0;
    credit    = 1'b0;
    $readmemh("verif/shuffle_vectors.txt", vec_mem);
    waited = 0;
    while (!rst_n && waited < Timeout) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) abort_run("reset was never released");
    @(posedge clk);
    #2;
    checks++;
    assert (!out_valid && req_ready && in_ready) else begin
      $display("** Error reset_idle out_valid/req_ready/in_ready: expected 011, got %0b%0b%0b",
               out_valid, req_ready, in_ready);
      errors++;
    end
    first = 0;
    for (int r = 0; r < NumRows; r++) begin
      if (r == NumRows - 1 || vec_field(r + 1, 0) != vec_field(r, 0)) begin
        run_test(first, r);
        first = r + 1;
      end
    end
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
////////////////////
// Free-running clock and active-low reset for the testbench.
// Reset releases shortly after the last reset cycle's rising edge.
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned HalfPeriod  = 10,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hw/shuffle_unit.sv ====
////////////////////
// Read shuffle unit: reorders memory beats so each cluster gets its own lanes' elements.
// Requests must be accepted before their beats; output uses credits, no ready.
// Latency is NUM_STAGES cycles with credits available.
////////////////////

`timescale 1ns/1ns
`default_nettype none

module shuffle_unit #(
  parameter int unsigned NumTrackers = 4,
  parameter int unsigned CreditDepth = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Read requests
  input  logic                     req_valid_i,
  input  shuffle_req_pkg::rd_req_t req_i,
  output logic                     req_ready_o,
  // Beats from memory
  input  logic                     in_valid_i,
  input  shuffle_req_pkg::beat_t   in_beat_i,
  output logic                     in_ready_o,
  // Beats to the clusters
  output logic                     out_valid_o,
  output shuffle_req_pkg::beat_t   out_beat_o,
  input  logic                     credit_i
);

  localparam int unsigned NStg = shuffle_cfg_pkg::NUM_STAGES;

  // Index 0 is the memory side, index NStg the output side
  logic                   [NStg:0] chain_valid;
  logic                   [NStg:0] chain_ready;
  shuffle_req_pkg::beat_t [NStg:0] chain_beat;

  shuffle_req_pkg::stage_cfg_t [NStg-1:0] stage_cfg;
  logic                        [NStg-1:0] stage_done;

  logic credit_avail;

  ////////////////////
  // Request tracking
  ////////////////////

  req_tracker #(
    .NumTrackers (NumTrackers)
  ) i_req_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .stage_done_i (stage_done),
    .stage_cfg_o  (stage_cfg)
  );

  ////////////////////
  // Stage chain
  ////////////////////

  assign chain_valid[0] = in_valid_i;
  assign chain_beat[0]  = in_beat_i;
  assign in_ready_o     = chain_ready[0];

  for (genvar s = 0; s < NStg; s++) begin : g_stage
    shuffle_stage #(
      .Level (s)
    ) i_shuffle_stage (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .valid_i      (chain_valid[s]),
      .ready_o      (chain_ready[s]),
      .beat_i       (chain_beat[s]),
      .enable_i     (stage_cfg[s][s]),
      .valid_o      (chain_valid[s+1]),
      .ready_i      (chain_ready[s+1]),
      .beat_o       (chain_beat[s+1]),
      .stage_done_o (stage_done[s])
    );
  end

  ////////////////////
  // Credit output
  ////////////////////

  credit_counter #(
    .CreditDepth (CreditDepth)
  ) i_credit_counter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .credit_i (credit_i),
    .spend_i  (out_valid_o),
    .avail_o  (credit_avail)
  );

  // All clusters take the beat together, so one credit pool stands in for ready
  assign chain_ready[NStg] = credit_avail;
  assign out_valid_o       = chain_valid[NStg] & credit_avail;
  assign out_beat_o        = chain_beat[NStg];

endmodule

`default_nettype wire

// ==== hw/credit_counter.sv ====
////////////////////
// Output credits held from the consumer.
// Starts full; the consumer never returns more than it was sent.
////////////////////

`timescale 1ns/1ns
`default_nettype none

module credit_counter #(
  parameter int unsigned CreditDepth = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic credit_i,
  input  logic spend_i,
  output logic avail_o
);

  localparam int unsigned CntW = $clog2(CreditDepth + 1);

  typedef logic [CntW-1:0] credit_cnt_t;

  credit_cnt_t credit_q;

  // A returned credit counts from the next cycle on
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= credit_cnt_t'(CreditDepth);
    end else begin
      credit_q <= credit_q + credit_cnt_t'(credit_i) - credit_cnt_t'(spend_i);
    end
  end

  assign avail_o = (credit_q != '0);

  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= credit_cnt_t'(CreditDepth));

  // Top level must only send while a credit is held
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    spend_i |-> (credit_q != '0));

endmodule

`default_nettype wire

// ==== hw/shuffle_stage.sv ====
////////////////////
// One shuffle level: a one-entry valid/ready register with the block swap on its output.
// Beat width must hold a whole number of four-block groups at this level.
////////////////////

`timescale 1ns/1ns
`default_nettype none

module shuffle_stage #(
  parameter int unsigned Level = 0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  shuffle_req_pkg::beat_t beat_i,
  input  logic                   enable_i,
  output logic                   valid_o,
  input  logic                   ready_i,
  output shuffle_req_pkg::beat_t beat_o,
  output logic                   stage_done_o
);

  localparam int unsigned Block     = shuffle_cfg_pkg::BASE_BLOCK << Level;
  localparam int unsigned NumGroups = shuffle_cfg_pkg::TOTAL_DATA_WIDTH / (4 * Block);

  logic                        valid_q;
  shuffle_req_pkg::beat_t      beat_q;
  shuffle_cfg_pkg::beat_data_t swapped;

  ////////////////////
  // Holding register
  ////////////////////

  // Takes a new beat when empty or when the held one leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      beat_q <= beat_i;
    end
  end

  ////////////////////
  // Block swap
  ////////////////////

  // Middle two blocks of every group of four trade places
  always_comb begin
    swapped = beat_q.data;
    for (int g = 0; g < NumGroups; g++) begin
      swapped[(4*g+1)*Block +: Block] = beat_q.data[(4*g+2)*Block +: Block];
      swapped[(4*g+2)*Block +: Block] = beat_q.data[(4*g+1)*Block +: Block];
    end
  end

  always_comb begin
    beat_o = beat_q;
    if (enable_i) begin
      beat_o.data = swapped;
    end
  end

  assign valid_o      = valid_q;
  // Tells the tracker this level is finished with the request
  assign stage_done_o = valid_q & ready_i & beat_q.last;

  // Tracker must not switch config under a beat that is waiting
  a_enable_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i) |=> $stable(enable_i));

endmodule

`default_nettype wire

// ==== hw/req_tracker.sv ====
////////////////////
// Queue of accepted read requests, one issue pointer per shuffle stage.
// A request must be accepted before its first beat enters the pipeline.
// Entries are freed when the last beat leaves the final stage.
////////////////////

`timescale 1ns/1ns
`default_nettype none

module req_tracker #(
  parameter int unsigned NumTrackers = 4
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic                                                    req_valid_i,
  input  shuffle_req_pkg::rd_req_t                                req_i,
  output logic                                                    req_ready_o,
  input  logic                       [shuffle_cfg_pkg::NUM_STAGES-1:0] stage_done_i,
  output shuffle_req_pkg::stage_cfg_t [shuffle_cfg_pkg::NUM_STAGES-1:0] stage_cfg_o
);

  localparam int unsigned PtrW = (NumTrackers > 1) ? $clog2(NumTrackers) : 1;
  localparam int unsigned CntW = $clog2(NumTrackers + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  shuffle_req_pkg::stage_cfg_t [NumTrackers-1:0] cfg_q;
  shuffle_req_pkg::stage_cfg_t                   new_cfg;

  ptr_t                                    accept_ptr_q;
  ptr_t [shuffle_cfg_pkg::NUM_STAGES-1:0]  issue_ptr_q;
  cnt_t                                    cnt_q;

  logic accept;
  logic retire;

  function automatic ptr_t wrap_inc(ptr_t ptr);
    return (ptr == ptr_t'(NumTrackers - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign req_ready_o = (cnt_q != cnt_t'(NumTrackers));
  assign accept      = req_valid_i & req_ready_o;
  // Final stage done means the request has fully left the unit
  assign retire      = stage_done_i[shuffle_cfg_pkg::NUM_STAGES-1];

  // Level s swaps for every element narrower than its block
  always_comb begin
    new_cfg = '0;
    for (int s = 0; s < shuffle_cfg_pkg::NUM_STAGES; s++) begin
      new_cfg[s] = (int'(req_i.ew) <= s);
    end
  end

  ////////////////////
  // Queue storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cfg_q[accept_ptr_q] <= new_cfg;
    end
  end

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q <= '0;
      issue_ptr_q  <= '0;
      cnt_q        <= '0;
    end else begin
      if (accept) begin
        accept_ptr_q <= wrap_inc(accept_ptr_q);
      end
      // Each stage moves on once the last beat of its request has passed
      for (int s = 0; s < shuffle_cfg_pkg::NUM_STAGES; s++) begin
        if (stage_done_i[s]) begin
          issue_ptr_q[s] <= wrap_inc(issue_ptr_q[s]);
        end
      end
      cnt_q <= cnt_q + cnt_t'(accept) - cnt_t'(retire);
    end
  end

  // Every stage sees the enables of the request it is working on
  for (genvar s = 0; s < shuffle_cfg_pkg::NUM_STAGES; s++) begin : g_cfg_out
    assign stage_cfg_o[s] = cfg_q[issue_ptr_q[s]];
  end

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= cnt_t'(NumTrackers));

  // A beat in flight always belongs to a tracked request
  a_done_needs_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q == '0) |-> (stage_done_i == '0));

endmodule

`default_nettype wire

// ==== hw/shuffle_req_pkg.sv ====
////////////////////
// Records exchanged between the tracker, the stages and the top level.
// Built on the geometry of shuffle_cfg_pkg.
////////////////////

`default_nettype none

package shuffle_req_pkg;

  ////////////////////
  // Read request
  ////////////////////

  // One accepted read burst
  typedef struct packed {
    // Element width the beats are shuffled for
    shuffle_cfg_pkg::ew_t       ew;
    // Burst length as issued to memory
    shuffle_cfg_pkg::beat_len_t len;
  } rd_req_t;

  ////////////////////
  // Data beat
  ////////////////////

  // One beat moving through the pipeline
  typedef struct packed {
    shuffle_cfg_pkg::beat_data_t data;
    // Marks the final beat of its request
    logic                        last;
  } beat_t;

  ////////////////////
  // Stage config
  ////////////////////

  // Bit s enables the block swap of level s
  typedef logic [shuffle_cfg_pkg::NUM_STAGES-1:0] stage_cfg_t;

endpackage

`default_nettype wire

// ==== hw/shuffle_cfg_pkg.sv ====
////////////////////
// Geometry of the read shuffle pipeline.
// NUM_STAGES assumes CLUSTER_DATA_WIDTH is a power-of-two multiple of 8*NR_LANES.
// Element widths above 32 bits are not supported.
////////////////////

`default_nettype none

package shuffle_cfg_pkg;

  ////////////////////
  // Cluster geometry
  ////////////////////

  // Lanes in one cluster
  localparam int unsigned NR_LANES = 2;

  // Clusters fed by one beat
  localparam int unsigned NR_CLUSTERS = 4;

  // Bits delivered to one cluster per beat
  localparam int unsigned CLUSTER_DATA_WIDTH = 64;

  // Bits of one full memory beat
  localparam int unsigned TOTAL_DATA_WIDTH = NR_CLUSTERS * CLUSTER_DATA_WIDTH;

  ////////////////////
  // Shuffle levels
  ////////////////////

  // One level per doubling of the block, from 8*NR_LANES up to half a cluster
  localparam int unsigned NUM_STAGES = $clog2(CLUSTER_DATA_WIDTH / (8 * NR_LANES));

  // Block moved at level 0, doubles every level
  localparam int unsigned BASE_BLOCK = 8 * NR_LANES;

  ////////////////////
  // Vector types
  ////////////////////

  typedef logic [TOTAL_DATA_WIDTH-1:0] beat_data_t;

  // Element width code: 0 is 8 bit, 1 is 16 bit, 2 is 32 bit
  typedef logic [1:0] ew_t;

  // Beats in a burst minus one, AXI style
  typedef logic [7:0] beat_len_t;

endpackage

`default_nettype wire
